//--- vlog.f
design/tart_pkg.sv
design/sample_capture.sv
design/block_buffer.sv
design/aq_scheduler.sv
design/sample_store.sv
design/tart_acquire_top.sv
test/tart_acquire_checker.sv
test/tart_acquire_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the acquisition testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tart_acquire_tb \
   -o tart_sim > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

# A crash without the closing report still counts as a failure
./obj_dir/tart_sim > "$LOG" 2>&1 || echo ">>> FAIL" >> "$LOG"
cat "$LOG"

grep -q ">>> FAIL" "$LOG" \
   && { echo "Simulation failed"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

//--- test/tart_acquire_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tart_acquire_tb;

   localparam int BLOCK_LEN   = 64;
   localparam int BUF_DEPTH   = 8;
   localparam int ADDR_W      = 6;
   localparam int STB_SPACING = 4;    // Slow strobe, no drops expected
   localparam int NUM_BLOCKS  = 5;    // Blocks started over the whole run
   localparam int DONE_WAIT   = BLOCK_LEN * 3 + 200;
   localparam int WATCHDOG_CYCLES =
      NUM_BLOCKS * (BLOCK_LEN * STB_SPACING + BLOCK_LEN * 3 + 200);

   // DUT side
   logic                    fpga_clk;
   logic                    rst_n;
   logic [23:0]             antenna;
   logic                    sample_stb;
   logic                    start_aq;
   logic                    fake_src;
   logic                    aq_busy;
   logic                    aq_done;
   logic                    overflow;
   logic                    rd_en;
   logic [ADDR_W-1:0]       rd_addr;
   logic [23:0]             rd_data;
   logic                    rd_valid;

   // Checker side
   logic [23:0]             exp_data;    // Reference word for the read issued now
   logic                    mono_mode;   // Overflow block, order check only
   logic [31:0]             mono_limit;  // Strobes sent in that block
   logic                    flag_chk;
   logic [3:0]              flag_exp;    // {busy, done, overflow, rd_valid}
   int                      chk_errors;
   int                      tb_errors;   // Timeouts seen here

   integer                  seed;
   logic [23:0]             rec_words [$];  // Antenna words of the current block
   logic                    fake_ref;       // Block taken from the fake counter
   int                      sent;

   tart_acquire_top #(
      .BLOCK_LEN(BLOCK_LEN), .BUF_DEPTH(BUF_DEPTH), .ADDR_W(ADDR_W)
   ) dut0 (
      .fpga_clk(fpga_clk), .rst_n(rst_n),
      .antenna(antenna), .sample_stb(sample_stb),
      .start_aq(start_aq), .fake_src(fake_src),
      .aq_busy(aq_busy), .aq_done(aq_done), .overflow(overflow),
      .rd_en(rd_en), .rd_addr(rd_addr),
      .rd_data(rd_data), .rd_valid(rd_valid)
   );

   tart_acquire_checker chk0 (
      .fpga_clk(fpga_clk), .rst_n(rst_n),
      .aq_busy(aq_busy), .aq_done(aq_done), .overflow(overflow),
      .rd_en(rd_en), .rd_valid(rd_valid), .rd_data(rd_data),
      .exp_data(exp_data), .mono_mode(mono_mode), .mono_limit(mono_limit),
      .flag_chk(flag_chk), .flag_exp(flag_exp),
      .err_count(chk_errors)
   );

   // --------------------
   // Clock and watchdog
   // --------------------
   initial
   begin
      fpga_clk = 1'b0;
      forever #10 fpga_clk = ~fpga_clk;  // 50 MHz
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge fpga_clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   // Word expected at store address i
   function automatic logic [23:0] expected_sample(input int i);
      if (fake_ref)
         return 24'(i);   // Every strobe accepted, counter equals index
      return rec_words[i];
   endfunction

   // --------------------
   // Stimulus tasks
   // --------------------
   task automatic start_block(input logic fake);
      int n;
      n = 0;
      fake_src <= fake;
      fake_ref = fake;
      rec_words.delete();
      start_aq <= 1'b1;
      @(posedge fpga_clk);
      start_aq <= 1'b0;
      @(posedge fpga_clk);
      while (!aq_busy && n < 10)
      begin
         @(posedge fpga_clk);
         n++;
      end
      if (!aq_busy)
      begin
         tb_errors++;
         $display("Start pulse did not raise aq_busy at %0d ns", $time);
      end
   endtask

   task automatic send_strobes(input int count, input int spacing);
      logic [31:0] word;
      for (int k = 0; k < count; k++)
      begin
         word = $random(seed);
         antenna    <= word[23:0];
         sample_stb <= 1'b1;
         rec_words.push_back(word[23:0]);
         @(posedge fpga_clk);
         sample_stb <= 1'b0;
         repeat (spacing - 1) @(posedge fpga_clk);
      end
   endtask

   // Strobe every cycle until the block is stored
   task automatic strobe_until_done(output int count);
      logic [31:0] word;
      count = 0;
      sample_stb <= 1'b1;
      while (!aq_done && count < BLOCK_LEN * STB_SPACING)
      begin
         word = $random(seed);
         antenna <= word[23:0];
         @(posedge fpga_clk);
         count++;
      end
      sample_stb <= 1'b0;
      if (!aq_done)
      begin
         tb_errors++;
         $display("Timeout: aq_done did not rise during the fast strobe burst");
      end
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (!aq_done && n < DONE_WAIT)
      begin
         @(posedge fpga_clk);
         n++;
      end
      if (!aq_done)
      begin
         tb_errors++;
         $display("Timeout: aq_done did not rise within %0d cycles", DONE_WAIT);
      end
   endtask

   task automatic check_flags(input logic [3:0] want);
      flag_exp <= want;
      flag_chk <= 1'b1;   // Compared at the next edge
      @(posedge fpga_clk);
      flag_chk <= 1'b0;
   endtask

   task automatic read_block(input logic mono, input int limit);
      mono_mode  <= mono;
      mono_limit <= 32'(limit);
      for (int i = 0; i < BLOCK_LEN; i++)
      begin
         rd_en    <= 1'b1;
         rd_addr  <= ADDR_W'(i);
         exp_data <= expected_sample(i);
         @(posedge fpga_clk);
      end
      rd_en <= 1'b0;
      repeat (2) @(posedge fpga_clk);  // Last word reaches the checker
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial
   begin
      seed       = 32'h95d46277;
      tb_errors  = 0;
      fake_ref   = 1'b0;
      rst_n      <= 1'b0;
      antenna    <= '0;
      sample_stb <= 1'b0;
      start_aq   <= 1'b0;
      fake_src   <= 1'b0;
      rd_en      <= 1'b0;
      rd_addr    <= '0;
      exp_data   <= '0;
      mono_mode  <= 1'b0;
      mono_limit <= '0;
      flag_chk   <= 1'b0;
      flag_exp   <= '0;
      repeat (2) @(posedge fpga_clk);
      rst_n <= 1'b1;

      check_flags(4'b0000);            // Quiet after reset

      start_block(1'b0);               // Real antenna words
      send_strobes(BLOCK_LEN, STB_SPACING);
      wait_done();
      check_flags(4'b0100);
      read_block(1'b0, 0);

      repeat (2)                       // Fake source, counter restarts each time
      begin
         start_block(1'b1);
         send_strobes(BLOCK_LEN, STB_SPACING);
         wait_done();
         check_flags(4'b0100);
         read_block(1'b0, 0);
      end

      start_block(1'b1);               // Strobe every cycle, drops expected
      strobe_until_done(sent);
      check_flags(4'b0110);
      read_block(1'b1, sent);

      start_block(1'b0);               // Start clears done and overflow
      check_flags(4'b1000);
      send_strobes(20, STB_SPACING);
      start_aq <= 1'b1;                // Ignored, block is busy
      @(posedge fpga_clk);
      start_aq <= 1'b0;
      send_strobes(BLOCK_LEN - 20, STB_SPACING);
      wait_done();
      check_flags(4'b0100);
      read_block(1'b0, 0);

      $display("Errors: %0d data or status, %0d timeout", chk_errors, tb_errors);
      if (chk_errors == 0 && tb_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tart_acquire_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tart_acquire_checker (
   input  wire logic                          fpga_clk,
   input  wire logic                          rst_n,
   input  wire logic                          aq_busy,
   input  wire logic                          aq_done,
   input  wire logic                          overflow,
   input  wire logic                          rd_en,
   input  wire logic                          rd_valid,
   input  wire logic [tart_pkg::SAMPLE_W-1:0] rd_data,
   input  wire logic [tart_pkg::SAMPLE_W-1:0] exp_data,    // Paired with rd_en
   input  wire logic                          mono_mode,   // Order check, no exact word
   input  wire logic [31:0]                   mono_limit,  // Highest allowed value
   input  wire logic                          flag_chk,
   input  wire logic [3:0]                    flag_exp,    // {busy, done, overflow, rd_valid}
   output int                                 err_count
);

   logic [tart_pkg::SAMPLE_W-1:0] exp_q;      // Expected word, aligned with rd_valid
   logic                          pend_q;     // Read issued last cycle
   logic [tart_pkg::SAMPLE_W-1:0] prev_data;  // Previous readback in order mode
   logic                          have_prev;
   logic [3:0]                    flags_now;

   assign flags_now = {aq_busy, aq_done, overflow, rd_valid};

   task automatic report_error(input string what);
      $display("[ERROR] %0d ns: %s", $time, what);
      err_count++;
   endtask

   // --------------------
   // Compare process
   // --------------------
   always @(posedge fpga_clk)
   begin
      if (!rst_n)
      begin
         pend_q    <= 1'b0;
         have_prev <= 1'b0;
      end
      else
      begin
         pend_q <= rd_en;
         exp_q  <= exp_data;
         if (aq_busy)
            have_prev <= 1'b0;  // New block, new sequence

         // Read port timing
         if (rd_valid && !pend_q)
            report_error("rd_valid without a read one cycle earlier");
         if (pend_q && !rd_valid)
            report_error("read request got no rd_valid");

         if (rd_valid && pend_q)
         begin
            if (!mono_mode)
            begin
               if (rd_data !== exp_q)
                  report_error($sformatf("rd_data %h, expected %h", rd_data, exp_q));
            end
            else
            begin
               if (have_prev && rd_data <= prev_data)
                  report_error($sformatf("rd_data %0d not above previous %0d",
                                         rd_data, prev_data));
               if (32'(rd_data) > mono_limit)
                  report_error($sformatf("rd_data %0d above strobe count %0d",
                                         rd_data, mono_limit));
               prev_data <= rd_data;
               have_prev <= 1'b1;
            end
         end

         // Status outputs
         if (aq_busy && aq_done)
            report_error("aq_busy and aq_done high together");
         if (flag_chk && flags_now !== flag_exp)
            report_error($sformatf("busy/done/overflow/valid %b, expected %b",
                                   flags_now, flag_exp));
      end
   end

endmodule

`default_nettype wire

//--- design/tart_acquire_top.sv
`timescale 1ns/10ps
`default_nettype none

module tart_acquire_top #(
   parameter int BLOCK_LEN = tart_pkg::DEF_BLOCK_LEN,
   parameter int BUF_DEPTH = tart_pkg::DEF_BUF_DEPTH,
   parameter int ADDR_W    = tart_pkg::DEF_ADDR_W
) (
   input  wire logic                          fpga_clk,
   input  wire logic                          rst_n,
   input  wire logic [tart_pkg::SAMPLE_W-1:0] antenna,     // Radio data, 24 antennas
   input  wire logic                          sample_stb,
   input  wire logic                          start_aq,
   input  wire logic                          fake_src,
   output logic                               aq_busy,
   output logic                               aq_done,
   output logic                               overflow,
   input  wire logic                          rd_en,
   input  wire logic [ADDR_W-1:0]             rd_addr,
   output logic [tart_pkg::SAMPLE_W-1:0]      rd_data,
   output logic                               rd_valid
);

   // --------------------
   // Interconnect
   // --------------------
   logic                 push;
   logic                 full;
   logic                 empty;
   logic                 pop;
   logic                 ack;
   logic                 capturing;
   logic                 writing;
   logic                 start_ok;  // Start honored only when idle
   tart_pkg::aq_sample_t cap_sample;
   tart_pkg::aq_sample_t head;
   tart_pkg::wb_req_t    wb;

   assign aq_busy  = capturing || writing;
   assign start_ok = start_aq && !aq_busy;

   // Producer
   sample_capture #(.BLOCK_LEN(BLOCK_LEN)) cap0 (
      .fpga_clk(fpga_clk), .rst_n(rst_n),
      .antenna(antenna), .sample_stb(sample_stb),
      .start_aq(start_ok), .fake_src(fake_src),
      .full(full), .push(push), .sample(cap_sample),
      .capturing(capturing), .overflow(overflow)
   );

   block_buffer #(.DEPTH(BUF_DEPTH)) buf0 (
      .fpga_clk(fpga_clk), .rst_n(rst_n),
      .push(push), .wr_sample(cap_sample),
      .pop(pop), .rd_sample(head),
      .full(full), .empty(empty)
   );

   // Consumer, Wishbone master
   aq_scheduler #(.ADDR_W(ADDR_W)) sch0 (
      .fpga_clk(fpga_clk), .rst_n(rst_n),
      .start_aq(start_ok), .empty(empty), .head(head),
      .pop(pop), .wb(wb), .ack(ack),
      .writing(writing), .aq_done(aq_done)
   );

   sample_store #(.ADDR_W(ADDR_W)) store0 (
      .fpga_clk(fpga_clk), .rst_n(rst_n),
      .wb(wb), .ack(ack),
      .rd_en(rd_en), .rd_addr(rd_addr),
      .rd_data(rd_data), .rd_valid(rd_valid)
   );

endmodule

`default_nettype wire

//--- design/sample_store.sv
`timescale 1ns/10ps
`default_nettype none

module sample_store #(
   parameter int ADDR_W = tart_pkg::DEF_ADDR_W
) (
   input  wire logic                          fpga_clk,
   input  wire logic                          rst_n,
   input  wire tart_pkg::wb_req_t             wb,
   output logic                               ack,
   input  wire logic                          rd_en,
   input  wire logic [ADDR_W-1:0]             rd_addr,
   output logic [tart_pkg::SAMPLE_W-1:0]      rd_data,
   output logic                               rd_valid
);

   localparam int WORDS = 2 ** ADDR_W;

   logic [tart_pkg::SAMPLE_W-1:0] mem [WORDS];
   logic                          wb_hit;  // First cycle of a request

   // ack still low means this request has not been served
   assign wb_hit = wb.cyc && wb.stb && !ack;

   // --------------------
   // Wishbone side
   // --------------------
   always_ff @(posedge fpga_clk)
   begin
      if (wb_hit && wb.we)
         mem[wb.adr[ADDR_W-1:0]] <= wb.dat;  // Upper address bits ignored
   end

   // Registered single-cycle ack
   always_ff @(posedge fpga_clk)
   begin
      if (!rst_n)
         ack <= 1'b0;
      else
         ack <= wb_hit;
   end

   // --------------------
   // Host read side
   // --------------------
   always_ff @(posedge fpga_clk)
   begin
      if (rd_en)
         rd_data <= mem[rd_addr];
   end

   always_ff @(posedge fpga_clk)
   begin
      if (!rst_n)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_en;  // Data one cycle after request
   end

   // One ack per request, master must drop stb after it
   a_single_ack : assert property (@(posedge fpga_clk) disable iff (!rst_n)
      ack |=> !wb.stb);

endmodule

`default_nettype wire

//--- design/aq_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

module aq_scheduler #(
   parameter int ADDR_W = tart_pkg::DEF_ADDR_W
) (
   input  wire logic                 fpga_clk,
   input  wire logic                 rst_n,
   input  wire logic                 start_aq,  // Already gated by busy
   input  wire logic                 empty,
   input  wire tart_pkg::aq_sample_t head,
   output logic                      pop,
   output tart_pkg::wb_req_t         wb,
   input  wire logic                 ack,
   output logic                      writing,   // Block in progress on store side
   output logic                      aq_done
);

   tart_pkg::sch_state_e          state;
   logic [ADDR_W-1:0]             addr_q;  // Next store address
   logic [tart_pkg::SAMPLE_W-1:0] dat_q;   // Sample being written
   logic                          last_q;  // It closes the block

   // --------------------
   // Outputs
   // --------------------
   assign pop = (state == tart_pkg::SCH_POP) && !empty;

   // Bus held from the state register, so stable until ack
   always_comb
   begin
      wb.cyc = (state == tart_pkg::SCH_WRITE);
      wb.stb = (state == tart_pkg::SCH_WRITE);
      wb.we  = (state == tart_pkg::SCH_WRITE);  // Write only
      wb.adr = 16'(addr_q);
      wb.dat = dat_q;
   end

   assign writing = (state == tart_pkg::SCH_POP) || (state == tart_pkg::SCH_WRITE);
   assign aq_done = (state == tart_pkg::SCH_DONE);

   // Head captured at the pop
   always_ff @(posedge fpga_clk)
   begin
      if (pop)
      begin
         dat_q  <= head.data;
         last_q <= head.last;
      end
   end

   // --------------------
   // FSM, three cycles per sample
   // --------------------
   always_ff @(posedge fpga_clk)
   begin
      if (!rst_n)
      begin
         state  <= tart_pkg::SCH_IDLE;
         addr_q <= '0;
      end
      else if (start_aq)
      begin
         state  <= tart_pkg::SCH_POP;  // Also clears aq_done
         addr_q <= '0;
      end
      else
      begin
         case (state)
            tart_pkg::SCH_POP:
               if (!empty)
                  state <= tart_pkg::SCH_WRITE;  // stb next cycle
            tart_pkg::SCH_WRITE:
               if (ack)
               begin
                  addr_q <= addr_q + 1'b1;
                  state  <= last_q ? tart_pkg::SCH_DONE : tart_pkg::SCH_POP;
               end
            default:
               state <= state;  // IDLE and DONE wait for start
         endcase
      end
   end

   // Slave only answers an open request
   a_ack_in_cycle : assert property (@(posedge fpga_clk) disable iff (!rst_n)
      ack |-> (wb.cyc && wb.stb));

   // Classic handshake, request frozen until the slave answers
   a_wb_stable : assert property (@(posedge fpga_clk) disable iff (!rst_n)
      (wb.stb && !ack) |=> $stable(wb));

endmodule

`default_nettype wire

//--- design/block_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module block_buffer #(
   parameter int DEPTH = tart_pkg::DEF_BUF_DEPTH
) (
   input  wire logic                 fpga_clk,
   input  wire logic                 rst_n,
   input  wire logic                 push,
   input  wire tart_pkg::aq_sample_t wr_sample,
   input  wire logic                 pop,
   output tart_pkg::aq_sample_t      rd_sample,  // Head, valid while !empty
   output logic                      full,
   output logic                      empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   tart_pkg::aq_sample_t mem [DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     count;   // Occupancy
   logic                 wr_ok;
   logic                 rd_ok;

   assign wr_ok = push && !full;  // Push into a full buffer is dropped here
   assign rd_ok = pop && !empty;
   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   // Show-ahead read
   assign rd_sample = mem[rd_ptr];

   // --------------------
   // Storage
   // --------------------
   always_ff @(posedge fpga_clk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= wr_sample;
   end

   // Pointers wrap at DEPTH, not at a power of two
   always_ff @(posedge fpga_clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   // Consumer must wait for data
   a_no_pop_empty : assert property (@(posedge fpga_clk) disable iff (!rst_n)
      pop |-> !empty);

   // Occupancy never passes DEPTH, so no push into a full buffer was taken
   a_no_push_full : assert property (@(posedge fpga_clk) disable iff (!rst_n)
      count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- design/sample_capture.sv
`timescale 1ns/10ps
`default_nettype none

module sample_capture #(
   parameter int BLOCK_LEN = tart_pkg::DEF_BLOCK_LEN
) (
   input  wire logic                          fpga_clk,
   input  wire logic                          rst_n,
   input  wire logic [tart_pkg::SAMPLE_W-1:0] antenna,
   input  wire logic                          sample_stb,
   input  wire logic                          start_aq,   // Already gated by busy
   input  wire logic                          fake_src,   // 1 selects debug counter
   input  wire logic                          full,
   output logic                               push,
   output tart_pkg::aq_sample_t               sample,
   output logic                               capturing,
   output logic                               overflow    // Sticky until next start
);

   localparam int CNT_W = $clog2(BLOCK_LEN + 1);

   tart_pkg::cap_state_e          state;
   logic [tart_pkg::SAMPLE_W-1:0] ant_q;     // I/O register
   logic                          stb_q;     // Strobe, aligned with ant_q
   logic [tart_pkg::SAMPLE_W-1:0] fake_cnt;  // Fake telescope
   logic [CNT_W-1:0]              acc_cnt;   // Accepted samples so far
   logic                          accept;

   // --------------------
   // I/O stage
   // --------------------
   always_ff @(posedge fpga_clk)
   begin
      ant_q <= antenna;  // Payload only
   end

   always_ff @(posedge fpga_clk)
   begin
      if (!rst_n)
         stb_q <= 1'b0;
      else
         stb_q <= sample_stb;
   end

   // --------------------
   // Source select and push
   // --------------------
   assign push        = stb_q && (state == tart_pkg::CAP_RUN);
   assign accept      = push && !full;   // Refused samples do not count
   assign sample.data = fake_src ? fake_cnt : ant_q;
   assign sample.last = (acc_cnt == CNT_W'(BLOCK_LEN - 1));
   assign capturing   = (state == tart_pkg::CAP_RUN);

   // Block FSM, fake counter, overflow flag
   always_ff @(posedge fpga_clk)
   begin
      if (!rst_n)
      begin
         state    <= tart_pkg::CAP_IDLE;
         fake_cnt <= '0;
         acc_cnt  <= '0;
         overflow <= 1'b0;
      end
      else if (start_aq)
      begin
         state    <= tart_pkg::CAP_RUN;  // Next edge, no matter where we were
         fake_cnt <= '0;
         acc_cnt  <= '0;
         overflow <= 1'b0;
      end
      else if (state == tart_pkg::CAP_RUN && stb_q)
      begin
         fake_cnt <= fake_cnt + 1'b1;  // Counts every strobe, kept or not
         if (full)
            overflow <= 1'b1;          // Sample dropped
         else
         begin
            acc_cnt <= acc_cnt + 1'b1;
            if (sample.last)
               state <= tart_pkg::CAP_DONE;
         end
      end
   end

   // Nothing reaches the buffer once the block is closed
   a_push_in_run : assert property (@(posedge fpga_clk) disable iff (!rst_n)
      accept |-> (acc_cnt < CNT_W'(BLOCK_LEN)));

endmodule

`default_nettype wire

//--- design/tart_pkg.sv
`default_nettype none

package tart_pkg;

   // --------------------
   // Sizes
   // --------------------
   localparam int SAMPLE_W      = 24;  // One bit per antenna
   localparam int DEF_BLOCK_LEN = 64;  // Samples per acquisition block
   localparam int DEF_BUF_DEPTH = 8;   // Block buffer entries
   localparam int DEF_ADDR_W    = 6;   // Sample store address bits

   // --------------------
   // Data path types
   // --------------------

   // One antenna sample plus end-of-block marker
   typedef struct packed {
      logic [SAMPLE_W-1:0] data;  // Antenna word, or fake counter
      logic                last;  // Final sample of the block
   } aq_sample_t;

   // Wishbone classic master outputs
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [15:0]         adr;  // Store decodes low bits only
      logic [SAMPLE_W-1:0] dat;
   } wb_req_t;

   // --------------------
   // State machines
   // --------------------

   // Capture side
   typedef enum logic [1:0] {
      CAP_IDLE,  // Nothing since reset
      CAP_RUN,   // Taking strobes
      CAP_DONE   // Block captured, wait for start
   } cap_state_e;

   // Store side
   typedef enum logic [1:0] {
      SCH_IDLE,   // Nothing since reset
      SCH_POP,    // Wait for head, pop it
      SCH_WRITE,  // Wishbone write in flight
      SCH_DONE    // Block stored, aq_done held
   } sch_state_e;

endpackage

`default_nettype wire
